// File: icache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache geometry constants, controller state encoding
// and the cpu cache operation encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package icache_pkg;

    // widths seen by the cpu and the buses
    localparam int addr_w     = 32;
    localparam int word_w     = 32;  // one instruction

    // geometry
    localparam int way_num    = 4;
    localparam int set_num    = 64;
    localparam int line_words = 4;
    localparam int line_w     = line_words * word_w;  // 128, word 0 in the low bits

    // address split: tag | index | byte offset
    localparam int offset_w   = $clog2(line_words * 4);
    localparam int index_w    = $clog2(set_num);
    localparam int tag_w      = addr_w - index_w - offset_w;  // 22

    localparam int way_w      = $clog2(way_num);
    localparam int plru_w     = way_num - 1;  // root plus one leaf per pair

    // miss path goes lookup -> miss_req -> refill -> refill_done -> lookup,
    // uncached path goes lookup -> unc_req -> unc_wait -> unc_done -> lookup
    typedef enum logic [2:0] {
        st_lookup      = 3'd0,
        st_miss_req    = 3'd1,
        st_refill      = 3'd2,
        st_refill_done = 3'd3,
        st_unc_req     = 3'd4,
        st_unc_wait    = 3'd5,
        st_unc_done    = 3'd6
    } ctrl_state_e;

    // cache operations the fetch stage may issue
    typedef enum logic {
        op_none          = 1'b0,
        op_index_invalid = 1'b1  // drop all ways of one index
    } cache_op_e;

endpackage

// File: icache_way_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one way of the icache: valid bits, tags and lines per set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_way_ram (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [icache_pkg::index_w-1:0]   rd_index,
    input  logic                             wr_en,
    input  logic                             inv_en,
    input  logic [icache_pkg::index_w-1:0]   wr_index,
    input  logic [icache_pkg::tag_w-1:0]     wr_tag,
    input  logic [icache_pkg::line_w-1:0]    wr_line,
    output logic                             rd_valid,
    output logic [icache_pkg::tag_w-1:0]     rd_tag,
    output logic [icache_pkg::line_w-1:0]    rd_line
);

    logic [icache_pkg::tag_w-1:0]  tag_mem  [icache_pkg::set_num];
    logic [icache_pkg::line_w-1:0] line_mem [icache_pkg::set_num];

    // valid bits kept in flops so reset and invalidate act at once
    logic [icache_pkg::set_num-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (inv_en) begin
                valid_q[wr_index] <= 1'b0;
            end else if (wr_en) begin
                valid_q[wr_index] <= 1'b1;  // refill marks the line live
            end
            rd_valid <= valid_q[rd_index];  // old value on a same-edge write
        end
    end

    // tag and line storage, read every cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
        rd_tag  <= tag_mem[rd_index];
        rd_line <= line_mem[rd_index];
    end

endmodule

// File: icache_plru.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tree pseudo-lru state for every set, victim pick and update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_plru (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [icache_pkg::index_w-1:0]  index,
    input  logic                            hit,
    input  logic [icache_pkg::way_w-1:0]    hit_way,
    output logic [icache_pkg::way_w-1:0]    victim
);

    // bit 0 root, bit 1 leaf of ways 0-1, bit 2 leaf of ways 2-3
    localparam int root_bit = 0;
    localparam int lo_bit   = 1;
    localparam int hi_bit   = 2;

    logic [icache_pkg::set_num-1:0][icache_pkg::plru_w-1:0] tree_q;
    logic [icache_pkg::plru_w-1:0]                         cur_bits;

    assign cur_bits = tree_q[index];

    // walk the tree as stored
    always_comb begin
        if (cur_bits[root_bit]) begin
            victim = {1'b1, cur_bits[hi_bit]};
        end else begin
            victim = {1'b0, cur_bits[lo_bit]};
        end
    end

    // point the path of the hit way away from it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (hit) begin
            tree_q[index][root_bit] <= ~hit_way[1];
            if (hit_way[1]) begin
                tree_q[index][hi_bit] <= ~hit_way[0];
            end else begin
                tree_q[index][lo_bit] <= ~hit_way[0];
            end
        end
    end

endmodule

// File: icache_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache controller: request buffer, hit check, word select,
// miss and uncached FSM, line bus and word bus requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_ctrl (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    // cpu side
    input  logic                                                    valid,
    input  logic [icache_pkg::addr_w-1:0]                           addr,
    input  logic                                                    cached,
    input  icache_pkg::cache_op_e                                   op,
    input  logic                                                    stall,
    output logic                                                    busy,
    output logic [icache_pkg::word_w-1:0]                           rdata,
    // way rams
    input  logic [icache_pkg::way_num-1:0]                          rd_valid,
    input  logic [icache_pkg::way_num-1:0][icache_pkg::tag_w-1:0]   rd_tag,
    input  logic [icache_pkg::way_num-1:0][icache_pkg::line_w-1:0]  rd_line,
    output logic [icache_pkg::index_w-1:0]                          ram_rd_index,
    output logic [icache_pkg::way_num-1:0]                          ram_wr_en,
    output logic                                                    ram_inv_en,
    output logic [icache_pkg::tag_w-1:0]                            ram_wr_tag,
    output logic [icache_pkg::line_w-1:0]                           ram_wr_line,
    // plru
    input  logic [icache_pkg::way_w-1:0]                            victim,
    output logic [icache_pkg::index_w-1:0]                          plru_index,
    output logic                                                    plru_hit,
    output logic [icache_pkg::way_w-1:0]                            hit_way,
    // line bus
    output logic                                                    rd_req,
    output logic [icache_pkg::addr_w-1:0]                           rd_addr,
    input  logic                                                    rd_rdy,
    input  logic                                                    ret_valid,
    input  logic [icache_pkg::line_w-1:0]                           ret_data,
    // word bus
    output logic                                                    urd_req,
    output logic [icache_pkg::addr_w-1:0]                           urd_addr,
    input  logic                                                    urd_rdy,
    input  logic                                                    uret_valid,
    input  logic [icache_pkg::word_w-1:0]                           uret_data
);

    icache_pkg::ctrl_state_e state, state_next;

    // incoming address fields
    logic [icache_pkg::tag_w-1:0]    in_tag;
    logic [icache_pkg::index_w-1:0]  in_index;
    logic [icache_pkg::offset_w-1:0] in_offset;

    // request buffer
    logic                            buf_valid;
    logic [icache_pkg::tag_w-1:0]    buf_tag;
    logic [icache_pkg::index_w-1:0]  buf_index;
    logic [icache_pkg::offset_w-1:0] buf_offset;
    logic                            buf_cached;
    icache_pkg::cache_op_e           buf_op;

    logic                            accept;
    logic                            fetch_req;  // buffered request wants data
    logic [icache_pkg::way_num-1:0]  hit_vec;
    logic                            cache_hit;
    logic [icache_pkg::line_w-1:0]   hit_line;
    logic [icache_pkg::offset_w-3:0] word_sel;
    logic [icache_pkg::word_w-1:0]   hit_word;
    logic [icache_pkg::word_w-1:0]   unc_word;

    assign in_tag    = addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign in_index  = addr[icache_pkg::offset_w +: icache_pkg::index_w];
    assign in_offset = addr[icache_pkg::offset_w-1:0];

    assign accept    = !stall && !busy;
    assign fetch_req = buf_valid && (buf_op == icache_pkg::op_none);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            buf_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_tag    <= in_tag;
            buf_index  <= in_index;
            buf_offset <= in_offset;
            buf_cached <= cached;
            buf_op     <= op;
        end
    end

    // tag compare on the ram outputs of the buffered set
    always_comb begin
        for (int i = 0; i < icache_pkg::way_num; i++) begin
            hit_vec[i] = rd_valid[i] && (rd_tag[i] == buf_tag);
        end
    end

    assign cache_hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < icache_pkg::way_num; i++) begin
            if (hit_vec[i]) begin
                hit_way = icache_pkg::way_w'(i);
            end
        end
    end

    assign hit_line = rd_line[hit_way];
    assign word_sel = buf_offset[icache_pkg::offset_w-1:2];
    assign hit_word = hit_line[word_sel*icache_pkg::word_w +: icache_pkg::word_w];

    // uncached word, never written into a way
    always_ff @(posedge clk) begin
        if (state == icache_pkg::st_unc_wait && uret_valid) begin
            unc_word <= uret_data;
        end
    end

    assign rdata = (state == icache_pkg::st_unc_done) ? unc_word : hit_word;

    always_comb begin
        case (state)
            icache_pkg::st_lookup:   busy = fetch_req && (!buf_cached || !cache_hit);
            icache_pkg::st_unc_done: busy = 1'b0;
            default:                 busy = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= icache_pkg::st_lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::st_lookup: begin
                if (fetch_req && !buf_cached) begin
                    state_next = icache_pkg::st_unc_req;
                end else if (fetch_req && !cache_hit) begin
                    state_next = icache_pkg::st_miss_req;
                end
            end
            icache_pkg::st_miss_req: begin
                if (rd_rdy) begin
                    state_next = icache_pkg::st_refill;
                end
            end
            icache_pkg::st_refill: begin
                if (ret_valid) begin
                    state_next = icache_pkg::st_refill_done;
                end
            end
            icache_pkg::st_refill_done: state_next = icache_pkg::st_lookup;
            icache_pkg::st_unc_req: begin
                if (urd_rdy) begin
                    state_next = icache_pkg::st_unc_wait;
                end
            end
            icache_pkg::st_unc_wait: begin
                if (uret_valid) begin
                    state_next = icache_pkg::st_unc_done;
                end
            end
            icache_pkg::st_unc_done: begin
                if (!stall) begin
                    state_next = icache_pkg::st_lookup;
                end
            end
            default: state_next = icache_pkg::st_lookup;
        endcase
    end

    // refill reads the buffered set, a stall keeps it so rdata holds
    assign ram_rd_index = (state == icache_pkg::st_refill ||
                           state == icache_pkg::st_refill_done || stall) ? buf_index : in_index;

    always_comb begin
        ram_wr_en = '0;
        if (state == icache_pkg::st_refill && ret_valid) begin
            ram_wr_en[victim] = 1'b1;
        end
    end

    assign ram_inv_en  = accept && valid && (op == icache_pkg::op_index_invalid);
    assign ram_wr_tag  = buf_tag;
    assign ram_wr_line = ret_data;

    // one pulse per consumed hit
    assign plru_index = buf_index;
    assign plru_hit   = (state == icache_pkg::st_lookup) && fetch_req && buf_cached
                        && cache_hit && !stall;

    assign rd_req   = (state == icache_pkg::st_miss_req);
    assign rd_addr  = {buf_tag, buf_index, {icache_pkg::offset_w{1'b0}}};
    assign urd_req  = (state == icache_pkg::st_unc_req);
    assign urd_addr = {buf_tag, buf_index, buf_offset};

endmodule

// File: icache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache top: controller, four way rams and the plru
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // cpu fetch port
    input  logic                                valid,
    input  logic [icache_pkg::addr_w-1:0]       addr,
    input  logic                                cached,
    input  icache_pkg::cache_op_e               op,
    input  logic                                stall,
    output logic                                busy,
    output logic [icache_pkg::word_w-1:0]       rdata,
    // line bus
    output logic                                rd_req,
    output logic [icache_pkg::addr_w-1:0]       rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic [icache_pkg::line_w-1:0]       ret_data,
    // word bus for uncached fetches
    output logic                                urd_req,
    output logic [icache_pkg::addr_w-1:0]       urd_addr,
    input  logic                                urd_rdy,
    input  logic                                uret_valid,
    input  logic [icache_pkg::word_w-1:0]       uret_data
);

    logic [icache_pkg::index_w-1:0]                          ram_rd_index;
    logic [icache_pkg::way_num-1:0]                          ram_wr_en;
    logic                                                    ram_inv_en;
    logic [icache_pkg::tag_w-1:0]                            ram_wr_tag;
    logic [icache_pkg::line_w-1:0]                           ram_wr_line;
    logic [icache_pkg::way_num-1:0]                          way_valid;
    logic [icache_pkg::way_num-1:0][icache_pkg::tag_w-1:0]   way_tag;
    logic [icache_pkg::way_num-1:0][icache_pkg::line_w-1:0]  way_line;
    logic [icache_pkg::index_w-1:0]                          plru_index;
    logic                                                    plru_hit;
    logic [icache_pkg::way_w-1:0]                            hit_way;
    logic [icache_pkg::way_w-1:0]                            victim;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .addr         (addr),
        .cached       (cached),
        .op           (op),
        .stall        (stall),
        .busy         (busy),
        .rdata        (rdata),
        .rd_valid     (way_valid),
        .rd_tag       (way_tag),
        .rd_line      (way_line),
        .ram_rd_index (ram_rd_index),
        .ram_wr_en    (ram_wr_en),
        .ram_inv_en   (ram_inv_en),
        .ram_wr_tag   (ram_wr_tag),
        .ram_wr_line  (ram_wr_line),
        .victim       (victim),
        .plru_index   (plru_index),
        .plru_hit     (plru_hit),
        .hit_way      (hit_way),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .urd_req      (urd_req),
        .urd_addr     (urd_addr),
        .urd_rdy      (urd_rdy),
        .uret_valid   (uret_valid),
        .uret_data    (uret_data)
    );

    // writes and invalidates use the same index the controller reads
    for (genvar i = 0; i < icache_pkg::way_num; i++) begin : g_way
        icache_way_ram u_way (
            .clk      (clk),
            .rst_n    (rst_n),
            .rd_index (ram_rd_index),
            .wr_en    (ram_wr_en[i]),
            .inv_en   (ram_inv_en),
            .wr_index (ram_rd_index),
            .wr_tag   (ram_wr_tag),
            .wr_line  (ram_wr_line),
            .rd_valid (way_valid[i]),
            .rd_tag   (way_tag[i]),
            .rd_line  (way_line[i])
        );
    end

    icache_plru u_plru (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (plru_index),
        .hit     (plru_hit),
        .hit_way (hit_way),
        .victim  (victim)
    );

endmodule

// File: icache_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache port assertions, bound to icache_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        busy,
    input logic        rd_req,
    input logic        rd_rdy,
    input logic [31:0] rd_addr,
    input logic        urd_req,
    input logic        urd_rdy
);

    int fail_count = 0;

    // word bus request is a level until the bus takes it
    a_unc_req_held: assert property (@(posedge clk) disable iff (!rst_n)
                                     urd_req && !urd_rdy |=> urd_req)
    else begin
        fail_count++;
        $error("word read request dropped before ready");
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                    rd_req && !rd_rdy |=> $stable(rd_addr))
    else begin
        fail_count++;
        $error("line read address changed while the request waited");
    end

    // request is a level until the bus takes it
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
                                 rd_req && !rd_rdy |=> rd_req)
    else begin
        fail_count++;
        $error("line read request dropped before ready");
    end

    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
    else begin
        fail_count++;
        $error("busy high right after reset");
    end

endmodule

bind icache_top icache_assert u_icache_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .busy    (busy),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_addr (rd_addr),
    .urd_req (urd_req),
    .urd_rdy (urd_rdy)
);

// File: icache_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache checker: returned words, bus addresses, read counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        busy,
    input  logic [31:0] rdata,
    input  logic        rd_req,
    input  logic [31:0] rd_addr,
    input  logic        urd_req,
    input  logic [31:0] urd_addr,
    input  int          test_num,
    input  logic [31:0] exp_addr,
    input  logic [31:0] exp_word,
    input  logic        exp_cached,
    input  logic        exp_inv,
    input  logic [3:0]  exp_reads,
    input  logic        resp_check,  // response visible this cycle
    input  logic        test_done,
    input  logic        timed_out,
    output int          err_count,
    output int          test_count
);

    int   line_reads;
    int   word_reads;
    int   test_errs;
    logic rd_req_q;
    logic urd_req_q;
    logic timeout_seen;

    task automatic mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        $display("Fail %s: got %h, expected %h in test %0d", name, got, exp, test_num);
        test_errs++;
        err_count++;
    endtask

    // sampled at the rising edge, half a cycle after the testbench drives
    always @(posedge clk) begin : check
        logic [31:0] exp_words;
        exp_words = (exp_cached || exp_inv) ? 32'd0 : 32'd1;
        if (!rst_n) begin
            line_reads   = 0;
            word_reads   = 0;
            test_errs    = 0;
            err_count    = 0;
            test_count   = 0;
            rd_req_q     = 1'b0;
            urd_req_q    = 1'b0;
            timeout_seen = 1'b0;
        end else begin
            if (rd_req && !rd_req_q) begin
                line_reads++;
                if (rd_addr !== {exp_addr[31:4], 4'h0}) begin
                    mismatch("rd_addr", rd_addr, {exp_addr[31:4], 4'h0});
                end
            end
            if (urd_req && !urd_req_q) begin
                word_reads++;
                if (urd_addr !== exp_addr) begin
                    mismatch("urd_addr", urd_addr, exp_addr);
                end
            end
            rd_req_q  = rd_req;
            urd_req_q = urd_req;
            if (resp_check) begin
                if (busy !== 1'b0) begin
                    mismatch("busy", {31'd0, busy}, 32'd0);
                end
                if (rdata !== exp_word) begin
                    mismatch("rdata", rdata, exp_word);
                end
            end
            if (timed_out && !timeout_seen) begin
                $display("test %0d: busy did not fall before the timeout", test_num);
                err_count++;
                timeout_seen = 1'b1;
            end
            if (test_done) begin
                if (line_reads != int'(exp_reads)) begin
                    mismatch("rd_req rises", 32'(line_reads), {28'd0, exp_reads});
                end
                if (32'(word_reads) != exp_words) begin
                    mismatch("urd_req rises", 32'(word_reads), exp_words);
                end
                $display("test %0d addr %h: %s, %0d line reads, %0d word reads", test_num,
                         exp_addr, (test_errs == 0) ? "ok" : "mismatch", line_reads, word_reads);
                test_count++;
                line_reads = 0;  // counts are per test
                word_reads = 0;
                test_errs  = 0;
            end
        end
    end

endmodule

// File: icache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache testbench: clock, reset, stimulus table, line bus
// and word bus memory models, closing report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module icache_tb;

    typedef struct packed {
        logic [31:0] addr;
        logic        cached;
        logic        inv;        // index invalidate instead of a fetch
        logic [3:0]  stall_cyc;  // stall held once the response shows
        logic [3:0]  reads;      // expected new line reads
    } row_t;

    logic                  clk, rst_n;
    logic                  valid, cached, stall, busy;
    icache_pkg::cache_op_e op;
    logic [31:0]           addr, rdata;
    logic                  rd_req, rd_rdy, ret_valid;
    logic [31:0]           rd_addr;
    logic [127:0]          ret_data;
    logic                  urd_req, urd_rdy, uret_valid;
    logic [31:0]           urd_addr, uret_data;

    // what the checker compares against
    int                    test_num;
    logic [31:0]           exp_addr, exp_word;
    logic                  exp_cached, exp_inv;
    logic [3:0]            exp_reads;
    logic                  resp_check, test_done, timed_out;
    int                    err_count, test_count;

    row_t rows [21] = '{
        '{32'h0000_1040, 1'b1, 1'b0, 4'd0, 4'd1},  // cold miss
        '{32'h0000_1044, 1'b1, 1'b0, 4'd0, 4'd0},
        '{32'h0000_1048, 1'b1, 1'b0, 4'd0, 4'd0},
        '{32'h0000_104c, 1'b1, 1'b0, 4'd0, 4'd0},
        '{32'h0000_1040, 1'b1, 1'b0, 4'd0, 4'd0},
        '{32'h2000_0084, 1'b0, 1'b0, 4'd0, 4'd0},  // uncached, twice
        '{32'h2000_0084, 1'b0, 1'b0, 4'd0, 4'd0},
        '{32'h0000_1040, 1'b1, 1'b1, 4'd0, 4'd0},  // drop index 4
        '{32'h0000_1048, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_0500, 1'b1, 1'b0, 4'd0, 4'd1},  // five tags into set 16
        '{32'h0000_0900, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_0d00, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_1100, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_1500, 1'b1, 1'b0, 4'd0, 4'd1},  // victim way 0
        '{32'h0000_0500, 1'b1, 1'b0, 4'd0, 4'd1},  // victims 2, 1, 3, 0
        '{32'h0000_0900, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_0d00, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_1100, 1'b1, 1'b0, 4'd0, 4'd1},
        '{32'h0000_0500, 1'b1, 1'b0, 4'd0, 4'd0},  // still in way 2
        '{32'h2000_0208, 1'b0, 1'b0, 4'd3, 4'd0},  // stall in unc_done
        '{32'h0000_104c, 1'b1, 1'b0, 4'd4, 4'd0}   // stall after a hit
    };

    icache_top u_icache_top (.*);

    icache_checker u_checker (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {2'b00, a[31:2]} ^ 32'h5a5a_0000;  // word address based
    endfunction

    function automatic logic [127:0] line_of(input logic [31:0] base);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = mem_word(base + 32'(w * 4));
        end
        return line;
    endfunction

    function automatic int bus_delay();
        return 1 + int'($urandom % 32'd4);
    endfunction

    task automatic present_row(input row_t r, input int num);
        int waited;
        test_num   = num;
        exp_addr   = r.addr;
        exp_word   = mem_word(r.addr);
        exp_cached = r.cached;
        exp_inv    = r.inv;
        exp_reads  = r.reads;
        valid      = 1'b1;
        addr       = r.addr;
        cached     = r.cached;
        if (r.inv) begin
            op = icache_pkg::op_index_invalid;
        end else begin
            op = icache_pkg::op_none;
        end
        @(negedge clk);  // taken at the rising edge in between
        valid  = 1'b0;
        waited = 0;
        while (busy && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            timed_out = 1'b1;
            @(negedge clk);
            return;
        end
        resp_check = !r.inv;
        if (r.stall_cyc != 4'd0) begin
            // decoy fetch that must not be taken while stalled
            stall = 1'b1;
            valid = 1'b1;
            addr  = r.addr ^ 32'h0000_0040;
            repeat (r.stall_cyc) @(negedge clk);
            stall = 1'b0;
            valid = 1'b0;
        end
        @(negedge clk);
        resp_check = 1'b0;
        test_done  = 1'b1;
        @(negedge clk);
        test_done  = 1'b0;
    endtask

    // line bus model
    initial begin : line_bus
        logic [31:0] base;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && rd_req) begin
                base = rd_addr;
                repeat (bus_delay()) @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                repeat (bus_delay()) @(negedge clk);
                ret_data  = line_of(base);
                ret_valid = 1'b1;
                @(negedge clk);
                ret_valid = 1'b0;
            end
        end
    end

    // word bus model, single words only
    initial begin : word_bus
        logic [31:0] waddr;
        urd_rdy    = 1'b0;
        uret_valid = 1'b0;
        uret_data  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && urd_req) begin
                waddr = urd_addr;
                repeat (bus_delay()) @(negedge clk);
                urd_rdy = 1'b1;
                @(negedge clk);
                urd_rdy = 1'b0;
                repeat (bus_delay()) @(negedge clk);
                uret_data  = mem_word(waddr);
                uret_valid = 1'b1;
                @(negedge clk);
                uret_valid = 1'b0;
            end
        end
    end

    initial begin
        int asserts;
        void'($urandom(20));
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid      = 1'b0;
        addr       = '0;
        cached     = 1'b0;
        op         = icache_pkg::op_none;
        stall      = 1'b0;
        test_num   = 0;
        exp_addr   = '0;
        exp_word   = '0;
        exp_cached = 1'b0;
        exp_inv    = 1'b0;
        exp_reads  = '0;
        resp_check = 1'b0;
        test_done  = 1'b0;
        timed_out  = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < $size(rows); i++) begin
            present_row(rows[i], i + 1);
            if (timed_out) begin
                break;
            end
        end
        @(negedge clk);
        asserts = u_icache_top.u_icache_assert.fail_count;
        $display("%0d tests, %0d checker errors, %0d assertion failures",
                 test_count, err_count, asserts);
        if (err_count == 0 && asserts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: list.f
icache_pkg.sv
icache_way_ram.sv
icache_plru.sv
icache_ctrl.sv
icache_top.sv
icache_assert.sv
icache_checker.sv
icache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = icache_tb
FILELIST  = list.f
RUNFLAGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
